// ==== cache_aq_sys.f ====
cache_aq_pkg.sv
aq_fifo.sv
aq_enq_port.sv
aq_arbiter.sv
cache_aq_sys.sv
cache_aq_checker.sv
cache_aq_monitor.sv
tb_cache_aq_sys.sv

// ==== Bender.yml ====
package:
  name: cache_aq_sys

sources:
  - cache_aq_pkg.sv
  - aq_fifo.sv
  - aq_enq_port.sv
  - aq_arbiter.sv
  - cache_aq_sys.sv
  - target: test
    files:
      - cache_aq_checker.sv
      - cache_aq_monitor.sv
      - tb_cache_aq_sys.sv

// ==== tb_cache_aq_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cache_aq_sys;

    localparam int unsigned SEED        = 54588;
    localparam int unsigned TOTAL_ITEMS = 4 * 24 + 3 * 12 + 6 * 4 + 2 * 6;
    localparam int unsigned WDOG_CYCLES = TOTAL_ITEMS * 200 + 16;

    logic                   clk = 1'b0;
    logic                   arst_n_i;
    logic                   rdsw_clr_i;
    logic                   wb_clr_i;
    logic                   out_ack_i;
    logic                   out_req_o;
    cache_aq_pkg::aq_line_t out_entry_o;
    cache_aq_pkg::aq_src_e  out_src_o;
    logic                   aq_empty_o;
    logic                   rd_full_o;
    logic                   sw_full_o;
    logic                   wb_full_o;
    // producer handshakes indexed by aq_src_e
    logic [3:0]             req;
    logic [3:0]             ack;
    cache_aq_pkg::aq_line_t ent [4];
    logic                   stall;
    int unsigned            errs;

    always #5 clk = ~clk;

    cache_aq_sys dut0 (
        .*,
        .rd_req_i (req[0]), .rd_entry_i (ent[0].req), .rd_ack_o (ack[0]),
        .sw_req_i (req[1]), .sw_entry_i (ent[1].req), .sw_ack_o (ack[1]),
        .wb_req_i (req[2]), .wb_entry_i (ent[2]),     .wb_ack_o (ack[2]),
        .bus_req_i(req[3]), .bus_entry_i(ent[3]),     .bus_ack_o(ack[3])
    );

    cache_aq_monitor mon0 (
        .clk(clk), .arst_n_i(arst_n_i), .rdsw_clr_i(rdsw_clr_i), .wb_clr_i(wb_clr_i),
        .rd_entry_i(ent[0].req), .sw_entry_i(ent[1].req), .wb_entry_i(ent[2]),
        .bus_entry_i(ent[3]), .bus_req_i(req[3]), .ack_i(ack),
        .out_req_i(out_req_o), .out_entry_i(out_entry_o), .out_src_i(out_src_o),
        .aq_empty_i(aq_empty_o), .full_i({wb_full_o, sw_full_o, rd_full_o})
    );

    function automatic cache_aq_pkg::aq_line_t rand_line();
        logic [191:0] bits;
        bits = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
        return cache_aq_pkg::aq_line_t'(bits[168:0]);
    endfunction

    // four-phase producer of n items with random gaps
    task automatic produce(input int src, input int n);
        cache_aq_pkg::aq_line_t e;
        for (int i = 0; i < n; i++) begin
            e = rand_line();
            repeat ($urandom_range(0, 6)) @(posedge clk);
            @(posedge clk);
            req[src] <= 1'b1;
            ent[src] <= e;
            do @(negedge clk); while (!ack[src]);
            @(posedge clk);
            req[src] <= 1'b0;
            do @(negedge clk); while (ack[src]);
        end
    endtask

    task automatic consume();
        forever begin
            do @(negedge clk); while (!out_req_o || stall);
            repeat ($urandom_range(0, 4)) @(posedge clk);
            @(posedge clk);
            out_ack_i <= 1'b1;
            do @(negedge clk); while (out_req_o);
            @(posedge clk);
            out_ack_i <= 1'b0;
        end
    endtask

    task automatic wait_drained();
        do @(negedge clk); while (!aq_empty_o || out_req_o || out_ack_i);
        repeat (4) @(negedge clk);
    endtask

    initial begin
        #(WDOG_CYCLES * 10);
        $display("Timeout: run did not finish within %0d cycles", WDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        arst_n_i   = 1'b0;
        rdsw_clr_i = 1'b0;
        wb_clr_i   = 1'b0;
        out_ack_i  = 1'b0;
        req        = '0;
        stall      = 1'b0;
        for (int s = 0; s < 4; s++) begin
            ent[s] = '0;
        end
        fork
            consume();
        join_none

        mon0.start_test("reset_state");
        repeat (16) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (4) @(posedge clk);
        mon0.finish_test();

        mon0.start_test("random_traffic");
        fork
            produce(0, 24);
            produce(1, 24);
            produce(2, 24);
            produce(3, 24);
        join
        wait_drained();
        mon0.finish_test();

        // consumer holds off until every queue has filled
        mon0.start_test("back_pressure");
        stall = 1'b1;
        fork
            produce(0, 12);
            produce(1, 12);
            produce(2, 12);
            begin
                do @(negedge clk); while (!(rd_full_o && sw_full_o && wb_full_o));
                repeat (30) @(posedge clk);
                stall = 1'b0;
            end
        join
        wait_drained();
        mon0.finish_test();

        mon0.start_test("clear");
        stall = 1'b1;
        fork
            produce(0, 4);
            produce(1, 4);
            produce(2, 4);
        join
        @(posedge clk);
        rdsw_clr_i <= 1'b1;
        @(posedge clk);
        rdsw_clr_i <= 1'b0;
        fork
            produce(0, 4);
            produce(1, 4);
        join
        stall = 1'b0;
        wait_drained();
        // wb clear keeps the entry already in the output register
        stall = 1'b1;
        produce(2, 4);
        @(posedge clk);
        wb_clr_i <= 1'b1;
        @(posedge clk);
        wb_clr_i <= 1'b0;
        stall = 1'b0;
        wait_drained();
        mon0.finish_test();

        mon0.start_test("status");
        fork
            produce(2, 6);
            produce(3, 6);
        join
        wait_drained();
        repeat (20) @(posedge clk);
        mon0.finish_test();

        errs = mon0.total_errs + dut0.u_arb.u_arb_chk.err_cnt
             + dut0.u_rd_q.u_fifo_chk.err_cnt + dut0.u_sw_q.u_fifo_chk.err_cnt
             + dut0.u_wb_q.u_fifo_chk.err_cnt;
        $display("%0d tests, %0d failed, %0d monitor errors, %0d assertion errors",
                 mon0.tests_run, mon0.tests_failed, mon0.total_errs, errs - mon0.total_errs);
        if (errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache_aq_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_aq_monitor (
    input wire logic                   clk,
    input wire logic                   arst_n_i,
    input wire logic                   rdsw_clr_i,
    input wire logic                   wb_clr_i,
    input wire cache_aq_pkg::aq_req_t  rd_entry_i,
    input wire cache_aq_pkg::aq_req_t  sw_entry_i,
    input wire cache_aq_pkg::aq_line_t wb_entry_i,
    input wire cache_aq_pkg::aq_line_t bus_entry_i,
    input wire logic                   bus_req_i,
    input wire logic [3:0]             ack_i,
    input wire logic                   out_req_i,
    input wire cache_aq_pkg::aq_line_t out_entry_i,
    input wire cache_aq_pkg::aq_src_e  out_src_i,
    input wire logic                   aq_empty_i,
    input wire logic [2:0]             full_i
);

    // expected queue contents, indexed by aq_src_e
    cache_aq_pkg::aq_line_t model_q [4][$];

    string       test_name    = "none";
    int unsigned test_errs    = 0;
    int unsigned test_checks  = 0;
    int unsigned total_errs   = 0;
    int unsigned tests_run    = 0;
    int unsigned tests_failed = 0;
    logic [3:0]  ack_q        = '0;
    logic        out_req_q    = 1'b0;
    logic        bus_avail_q  = 1'b0;
    logic        in_reset     = 1'b1;

    task automatic start_test(input string name);
        test_name   = name;
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d outputs checked, %0d errors", test_name,
                 (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
    endtask

    task automatic report_mismatch(input string what, input logic [168:0] exp,
                                   input logic [168:0] act);
        $display("Mismatch in test %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        test_errs++;
        total_errs++;
    endtask

    task automatic log_error(input string msg);
        $display("Error in test %s: %s", test_name, msg);
        test_errs++;
        total_errs++;
    endtask

    always @(posedge clk) begin : sample
        cache_aq_pkg::aq_src_e  exp_src;
        cache_aq_pkg::aq_line_t exp_entry;
        cache_aq_pkg::aq_line_t seen [4];
        logic                   exp_bit;
        if (!arst_n_i) begin
            for (int s = 0; s < 4; s++) begin
                model_q[s].delete();
            end
            in_reset = 1'b1;
        end else begin
            if (in_reset && (ack_i != '0 || out_req_i)) begin
                log_error("acks or out_req_o not low after reset");
            end
            in_reset = 1'b0;
            // the pick was one cycle ago, rank by the queues as they stood then
            exp_src = bus_avail_q ? cache_aq_pkg::SRC_BUS :
                      (model_q[2].size() != 0) ? cache_aq_pkg::SRC_WB :
                      (model_q[0].size() != 0) ? cache_aq_pkg::SRC_RD : cache_aq_pkg::SRC_SW;
            seen[0] = '{req: rd_entry_i, data: '0, mask: '0};
            seen[1] = '{req: sw_entry_i, data: '0, mask: '0};
            seen[2] = wb_entry_i;
            seen[3] = bus_entry_i;
            for (int s = 0; s < 4; s++) begin
                if (ack_i[s] && !ack_q[s]) model_q[s].push_back(seen[s]);
            end
            if (out_req_i && !out_req_q) begin
                test_checks++;
                if (model_q[out_src_i].size() == 0) begin
                    log_error($sformatf("output from source %0d with no accepted entry left",
                                        out_src_i));
                end else begin
                    exp_entry = model_q[out_src_i].pop_front();
                    if (out_src_i != exp_src) report_mismatch("out_src_o", exp_src, out_src_i);
                    if (out_entry_i !== exp_entry) begin
                        report_mismatch("out_entry_o", exp_entry, out_entry_i);
                    end
                end
            end
            for (int s = 0; s < 3; s++) begin
                if (model_q[s].size() > cache_aq_pkg::AQ_DEPTH) begin
                    log_error($sformatf("queue %0d accepted more entries than its depth", s));
                end
                exp_bit = (model_q[s].size() == cache_aq_pkg::AQ_DEPTH);
                if (full_i[s] !== exp_bit) report_mismatch($sformatf("full flag %0d", s),
                                                           exp_bit, full_i[s]);
            end
            exp_bit = (model_q[0].size() == 0) && (model_q[1].size() == 0) &&
                      (model_q[2].size() == 0) && !bus_req_i;
            if (aq_empty_i !== exp_bit) report_mismatch("aq_empty_o", exp_bit, aq_empty_i);
            if (rdsw_clr_i) begin
                model_q[0].delete();
                model_q[1].delete();
            end
            if (wb_clr_i) model_q[2].delete();
        end
        ack_q       = ack_i;
        out_req_q   = out_req_i;
        bus_avail_q = bus_req_i && !ack_i[3];
    end

endmodule

`default_nettype wire

// ==== cache_aq_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_aq_checker (
    input wire logic                   clk,
    input wire logic                   arst_n_i,
    input wire logic                   out_req_i,
    input wire logic                   out_ack_i,
    input wire cache_aq_pkg::aq_line_t out_entry_i,
    input wire logic                   push_i,
    input wire logic                   pop_i,
    input wire logic                   full_i,
    input wire logic                   empty_i
);

    int unsigned err_cnt = 0;

    offer_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_req_i && $past(out_req_i) |-> $stable(out_entry_i))
    else begin
        $error("out_entry_o changed while out_req_o was high");
        err_cnt++;
    end

    // a new offer only starts after the consumer released ack
    offer_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(out_req_i) |-> !out_ack_i)
    else begin
        $error("out_req_o rose while out_ack_i was high");
        err_cnt++;
    end

    no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
        push_i |-> !full_i)
    else begin
        $error("push into a full queue");
        err_cnt++;
    end

    no_underflow: assert property (@(posedge clk) disable iff (!arst_n_i)
        pop_i |-> !empty_i)
    else begin
        $error("pop from an empty queue");
        err_cnt++;
    end

endmodule

bind aq_arbiter cache_aq_checker u_arb_chk (
    .clk(clk), .arst_n_i(arst_n_i), .out_req_i(out_req_o), .out_ack_i(out_ack_i),
    .out_entry_i(out_entry_o), .push_i(1'b0), .pop_i(1'b0), .full_i(1'b0), .empty_i(1'b1)
);

bind aq_fifo cache_aq_checker u_fifo_chk (
    .clk(clk), .arst_n_i(arst_n_i), .out_req_i(1'b0), .out_ack_i(1'b0), .out_entry_i('0),
    .push_i(push_i), .pop_i(pop_i), .full_i(full_o), .empty_i(empty_o)
);

`default_nettype wire

// ==== cache_aq_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_aq_sys (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire logic                   rdsw_clr_i,
    input  wire logic                   wb_clr_i,

    input  wire logic                   rd_req_i,
    input  wire cache_aq_pkg::aq_req_t  rd_entry_i,
    output logic                        rd_ack_o,

    input  wire logic                   sw_req_i,
    input  wire cache_aq_pkg::aq_req_t  sw_entry_i,
    output logic                        sw_ack_o,

    input  wire logic                   wb_req_i,
    input  wire cache_aq_pkg::aq_line_t wb_entry_i,
    output logic                        wb_ack_o,

    input  wire logic                   bus_req_i,
    input  wire cache_aq_pkg::aq_line_t bus_entry_i,
    output logic                        bus_ack_o,

    output logic                        out_req_o,
    output cache_aq_pkg::aq_line_t      out_entry_o,
    output cache_aq_pkg::aq_src_e       out_src_o,
    input  wire logic                   out_ack_i,

    output logic                        aq_empty_o,
    output logic                        rd_full_o,
    output logic                        sw_full_o,
    output logic                        wb_full_o
);

    logic rd_push;
    logic sw_push;
    logic wb_push;

    cache_aq_pkg::aq_req_t  rd_push_entry;
    cache_aq_pkg::aq_req_t  sw_push_entry;
    cache_aq_pkg::aq_line_t wb_push_entry;

    cache_aq_pkg::aq_req_t  rd_head;
    cache_aq_pkg::aq_req_t  sw_head;
    cache_aq_pkg::aq_line_t wb_head;

    logic rd_empty;
    logic sw_empty;
    logic wb_empty;
    logic rd_pop;
    logic sw_pop;
    logic wb_pop;

    // load queue
    aq_enq_port #(.entry_t(cache_aq_pkg::aq_req_t)) u_rd_port (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (rd_req_i),
        .entry_i  (rd_entry_i),
        .ack_o    (rd_ack_o),
        .full_i   (rd_full_o),
        .push_o   (rd_push),
        .entry_o  (rd_push_entry)
    );

    aq_fifo #(.entry_t(cache_aq_pkg::aq_req_t)) u_rd_q (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (rdsw_clr_i),
        .push_i   (rd_push),
        .entry_i  (rd_push_entry),
        .pop_i    (rd_pop),
        .head_o   (rd_head),
        .empty_o  (rd_empty),
        .full_o   (rd_full_o)
    );

    // software store queue, cleared together with rd
    aq_enq_port #(.entry_t(cache_aq_pkg::aq_req_t)) u_sw_port (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (sw_req_i),
        .entry_i  (sw_entry_i),
        .ack_o    (sw_ack_o),
        .full_i   (sw_full_o),
        .push_o   (sw_push),
        .entry_o  (sw_push_entry)
    );

    aq_fifo #(.entry_t(cache_aq_pkg::aq_req_t)) u_sw_q (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (rdsw_clr_i),
        .push_i   (sw_push),
        .entry_i  (sw_push_entry),
        .pop_i    (sw_pop),
        .head_o   (sw_head),
        .empty_o  (sw_empty),
        .full_o   (sw_full_o)
    );

    // write-back queue carries full lines
    aq_enq_port #(.entry_t(cache_aq_pkg::aq_line_t)) u_wb_port (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (wb_req_i),
        .entry_i  (wb_entry_i),
        .ack_o    (wb_ack_o),
        .full_i   (wb_full_o),
        .push_o   (wb_push),
        .entry_o  (wb_push_entry)
    );

    aq_fifo #(.entry_t(cache_aq_pkg::aq_line_t)) u_wb_q (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .clr_i    (wb_clr_i),
        .push_i   (wb_push),
        .entry_i  (wb_push_entry),
        .pop_i    (wb_pop),
        .head_o   (wb_head),
        .empty_o  (wb_empty),
        .full_o   (wb_full_o)
    );

    aq_arbiter u_arb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_head_i   (rd_head),
        .sw_head_i   (sw_head),
        .wb_head_i   (wb_head),
        .rd_empty_i  (rd_empty),
        .sw_empty_i  (sw_empty),
        .wb_empty_i  (wb_empty),
        .rd_pop_o    (rd_pop),
        .sw_pop_o    (sw_pop),
        .wb_pop_o    (wb_pop),
        .bus_req_i   (bus_req_i),
        .bus_entry_i (bus_entry_i),
        .bus_ack_o   (bus_ack_o),
        .out_req_o   (out_req_o),
        .out_entry_o (out_entry_o),
        .out_src_o   (out_src_o),
        .out_ack_i   (out_ack_i),
        .aq_empty_o  (aq_empty_o)
    );

endmodule

`default_nettype wire

// ==== aq_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module aq_arbiter (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire cache_aq_pkg::aq_req_t  rd_head_i,
    input  wire cache_aq_pkg::aq_req_t  sw_head_i,
    input  wire cache_aq_pkg::aq_line_t wb_head_i,
    input  wire logic                   rd_empty_i,
    input  wire logic                   sw_empty_i,
    input  wire logic                   wb_empty_i,
    output logic                        rd_pop_o,
    output logic                        sw_pop_o,
    output logic                        wb_pop_o,
    input  wire logic                   bus_req_i,
    input  wire cache_aq_pkg::aq_line_t bus_entry_i,
    output logic                        bus_ack_o,
    output logic                        out_req_o,
    output cache_aq_pkg::aq_line_t      out_entry_o,
    output cache_aq_pkg::aq_src_e       out_src_o,
    input  wire logic                   out_ack_i,
    output logic                        aq_empty_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OFFER,
        ST_WAIT_LOW
    } arb_state_e;

    arb_state_e state_q;

    logic bus_ack_q;
    logic bus_avail;
    logic pick_valid;

    cache_aq_pkg::aq_src_e  pick_src;
    cache_aq_pkg::aq_line_t pick_entry;

    // bus is only a candidate once per handshake
    assign bus_avail = bus_req_i && !bus_ack_q;

    // bus > wb > rd > sw
    always_comb begin
        pick_src   = cache_aq_pkg::SRC_SW;
        pick_entry = '{req: sw_head_i, data: '0, mask: '0};
        if (bus_avail) begin
            pick_src   = cache_aq_pkg::SRC_BUS;
            pick_entry = bus_entry_i;
        end else if (!wb_empty_i) begin
            pick_src   = cache_aq_pkg::SRC_WB;
            pick_entry = wb_head_i;
        end else if (!rd_empty_i) begin
            pick_src   = cache_aq_pkg::SRC_RD;
            pick_entry = '{req: rd_head_i, data: '0, mask: '0};
        end
    end

    assign pick_valid = (state_q == ST_IDLE) && !out_ack_i &&
                        (bus_avail || !wb_empty_i || !rd_empty_i || !sw_empty_i);

    assign rd_pop_o = pick_valid && (pick_src == cache_aq_pkg::SRC_RD);
    assign sw_pop_o = pick_valid && (pick_src == cache_aq_pkg::SRC_SW);
    assign wb_pop_o = pick_valid && (pick_src == cache_aq_pkg::SRC_WB);

    assign bus_ack_o  = bus_ack_q;
    assign out_req_o  = (state_q == ST_OFFER);
    assign aq_empty_o = rd_empty_i && sw_empty_i && wb_empty_i && !bus_req_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            bus_ack_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE:     if (pick_valid) state_q <= ST_OFFER;
                ST_OFFER:    if (out_ack_i) state_q <= ST_WAIT_LOW;
                ST_WAIT_LOW: if (!out_ack_i) state_q <= ST_IDLE;
                default:     state_q <= ST_IDLE;
            endcase
            if (pick_valid && (pick_src == cache_aq_pkg::SRC_BUS)) begin
                bus_ack_q <= 1'b1;
            end else if (bus_ack_q && !bus_req_i) begin
                bus_ack_q <= 1'b0;
            end
        end
    end

    // output register, held until the consumer acks
    always_ff @(posedge clk) begin
        if (pick_valid) begin
            out_entry_o <= pick_entry;
            out_src_o   <= pick_src;
        end
    end

endmodule

`default_nettype wire

// ==== aq_enq_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module aq_enq_port #(
    parameter type entry_t = cache_aq_pkg::aq_req_t
) (
    input  wire logic   clk,
    input  wire logic   arst_n_i,
    input  wire logic   req_i,
    input  wire entry_t entry_i,
    output logic        ack_o,
    input  wire logic   full_i,
    output logic        push_o,
    output entry_t      entry_o
);

    logic ack_q;

    // one push per handshake, held off while the queue is full
    assign push_o  = req_i && !ack_q && !full_i;
    assign entry_o = entry_i;
    assign ack_o   = ack_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else if (push_o) begin
            ack_q <= 1'b1;
        end else if (ack_q && !req_i) begin
            // producer released req, close the handshake
            ack_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== aq_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module aq_fifo #(
    parameter type entry_t = cache_aq_pkg::aq_req_t
) (
    input  wire logic   clk,
    input  wire logic   arst_n_i,
    input  wire logic   clr_i,
    input  wire logic   push_i,
    input  wire entry_t entry_i,
    input  wire logic   pop_i,
    output entry_t      head_o,
    output logic        empty_o,
    output logic        full_o
);

    entry_t mem_q [cache_aq_pkg::AQ_DEPTH];

    logic [cache_aq_pkg::AQ_PTR_W-1:0] wr_ptr_q;
    logic [cache_aq_pkg::AQ_PTR_W-1:0] rd_ptr_q;
    logic [cache_aq_pkg::AQ_CNT_W-1:0] count_q;

    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == cache_aq_pkg::AQ_FULL_CNT);
    assign empty_o = (count_q == '0);
    assign head_o  = mem_q[rd_ptr_q];

    // overflow and underflow are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clr_i) begin
            // clear wins over a push or pop in the same cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == cache_aq_pkg::AQ_PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == cache_aq_pkg::AQ_PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage array
    always_ff @(posedge clk) begin
        if (do_push && !clr_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== cache_aq_pkg.sv ====
`default_nettype none

package cache_aq_pkg;

    // physical address and request fields
    localparam int unsigned AQ_ADDR_W = 15;
    localparam int unsigned AQ_SIZE_W = 2;
    localparam int unsigned AQ_ID_W   = 7;

    // one cache line, byte mask covers every byte
    localparam int unsigned AQ_LINE_BYTES = 16;
    localparam int unsigned AQ_DATA_W     = AQ_LINE_BYTES * 8;

    // queue geometry
    localparam int unsigned AQ_DEPTH = 8;
    localparam int unsigned AQ_PTR_W = $clog2(AQ_DEPTH);
    localparam int unsigned AQ_CNT_W = $clog2(AQ_DEPTH + 1);

    localparam logic [AQ_PTR_W-1:0] AQ_PTR_LAST = AQ_PTR_W'(AQ_DEPTH - 1);
    localparam logic [AQ_CNT_W-1:0] AQ_FULL_CNT = AQ_CNT_W'(AQ_DEPTH);

    // source of the entry sitting in the output register
    typedef enum logic [1:0] {
        SRC_RD  = 2'd0,
        SRC_SW  = 2'd1,
        SRC_WB  = 2'd2,
        SRC_BUS = 2'd3
    } aq_src_e;

    // rd/sw queue entry, 25 bits
    typedef struct packed {
        logic [AQ_ADDR_W-1:0] addr;
        logic [AQ_SIZE_W-1:0] size;
        logic [AQ_ID_W-1:0]   id;
        logic                 pcd;
    } aq_req_t;

    // wb/bus entry and output shape, 169 bits
    typedef struct packed {
        aq_req_t                  req;
        logic [AQ_DATA_W-1:0]     data;
        logic [AQ_LINE_BYTES-1:0] mask;
    } aq_line_t;

endpackage

`default_nettype wire
